//--- sim.f
+incdir+include
src/bru_pkg.sv
src/bru_lane_if.sv
src/bru_issue.sv
src/bru_lane.sv
src/bru_redirect.sv
src/bru_apb_regs.sv
src/bru_top.sv
tests/bru_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the branch resolution testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module bru_tb \
  -f sim.f \
  -o bru_sim

./obj_dir/bru_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed"
  exit 1
fi

//--- tests/bru_tb.sv
`include "bru_defs.svh"

module bru_tb;

  ////////////////////////////////////////
  // RV32I encodings
  ////////////////////////////////////////

  localparam logic [2:0]  F_BEQ  = 3'b000;
  localparam logic [2:0]  F_BNE  = 3'b001;
  localparam logic [2:0]  F_BLT  = 3'b100;
  localparam logic [2:0]  F_BGE  = 3'b101;
  localparam logic [2:0]  F_BLTU = 3'b110;
  localparam logic [2:0]  F_BGEU = 3'b111;
  // addi x0, x0, 0
  localparam logic [31:0] NOP    = 32'h0000_0013;
  localparam logic [31:0] FENCEI = 32'h0000_100F;
  // jalr x1 jumping to opa+opb
  localparam logic [31:0] JALR   = 32'h0000_80E7;

  localparam logic [31:0] SEED       = 32'h2f23_df27;
  localparam int          STALL_LEN  = 3;
  localparam int          APB_CYCLES = 64;

  typedef struct {
    string       name;
    logic [31:0] pc;
    logic [31:0] i0;
    logic [31:0] i1;
    logic [1:0]  v;
    logic [1:0]  p0;
    logic [1:0]  p1;
    logic [31:0] a0;
    logic [31:0] b0;
    logic [31:0] a1;
    logic [31:0] b1;
    bit          rnd;
    logic [31:0] exp_pc;
    // flush, cacheflush, misaligned, bp_btaken
    logic [3:0]  flags;
    // Accepted branches and their taken bits with the oldest in bit 0
    int          nbr;
    logic [1:0]  tkb;
    bit          misp;
    // Prediction of the lane that drives the outputs
    logic [1:0]  bpp;
  } row_t;

  logic                          clk;
  logic                          rstn;
  logic [`LANES-1:0]             issue_valid;
  logic [`LANES-1:0][`XLEN-1:0]  issue_pc;
  logic [`LANES-1:0][31:0]       issue_instr;
  logic [`LANES-1:0][`XLEN-1:0]  issue_opa;
  logic [`LANES-1:0][`XLEN-1:0]  issue_opb;
  logic [`LANES-1:0][1:0]        issue_predict;
  logic                          stall;
  logic [`XLEN-1:0]              nxt_pc;
  logic                          flush;
  logic                          cacheflush;
  logic                          exception_misaligned;
  logic                          bp_update;
  logic                          bp_btaken;
  logic [1:0]                    bp_predict;
  logic [`GHIST_BITS-1:0]        bp_history;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [`BRU_APB_AW-1:0]        paddr;
  logic [31:0]                   pwdata;
  logic [31:0]                   prdata;
  logic                          pready;
  logic                          pslverr;

  row_t  rows [$];
  int    errors;
  int    tests;
  int    failed;
  int    err_mark;
  string cur_test;
  int    cycles;
  int    limit;

  bru_top u_bru_top (.*);

  always #10 clk = ~clk;

  // Watchdog on a cycle budget
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: run did not end within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Encoders and bookkeeping
  ////////////////////////////////////////

  function automatic logic [31:0] br(input logic [2:0] f3, input int imm);
    logic [12:0] i;
    i = 13'(imm);
    // rs1=x1, rs2=x2
    return {i[12], i[10:5], 5'd2, 5'd1, f3, i[4:1], i[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int imm);
    logic [20:0] i;
    i = 21'(imm);
    return {i[20], i[10:1], i[11], i[19:12], 5'd1, 7'b1101111};
  endfunction

  task automatic add_row(input string name, input logic [31:0] pc, input logic [31:0] i0,
                         input logic [31:0] i1, input logic [1:0] v, input logic [1:0] p0,
                         input logic [1:0] p1, input logic [31:0] a0, input logic [31:0] b0,
                         input logic [31:0] a1, input logic [31:0] b1, input bit rnd,
                         input logic [31:0] exp_pc, input logic [3:0] flags, input int nbr,
                         input logic [1:0] tkb, input bit misp, input logic [1:0] bpp);
    row_t r;
    r.name   = name;
    r.pc     = pc;
    r.i0     = i0;
    r.i1     = i1;
    r.v      = v;
    r.p0     = p0;
    r.p1     = p1;
    r.a0     = a0;
    r.b0     = b0;
    r.a1     = a1;
    r.b1     = b1;
    r.rnd    = rnd;
    r.exp_pc = exp_pc;
    r.flags  = flags;
    r.nbr    = nbr;
    r.tkb    = tkb;
    r.misp   = misp;
    r.bpp    = bpp;
    rows.push_back(r);
  endtask

  task automatic compare_word(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s = 0x%08h, expected 0x%08h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic compare_bit(input string sig, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Error: %s = 0x%0h, expected 0x%0h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
    tests++;
  endtask

  task automatic finish_test();
    if (errors == err_mark) begin
      $display("pass  %s", cur_test);
    end else begin
      failed++;
      $display("fail  %s", cur_test);
    end
  endtask

  ////////////////////////////////////////
  // Bundle and APB drivers
  ////////////////////////////////////////

  // Called right after a rising edge
  task automatic apply_row(input row_t r);
    logic [31:0] a1;
    logic [31:0] b1;
    a1 = r.a1;
    b1 = r.b1;
    // Lane 1 is don't-care in these rows
    if (r.rnd) begin
      a1 = $urandom();
      b1 = $urandom();
    end
    issue_valid   <= r.v;
    issue_pc      <= {r.pc + 32'd4, r.pc};
    issue_instr   <= {r.i1, r.i0};
    issue_opa     <= {a1, r.a0};
    issue_opb     <= {b1, r.b0};
    issue_predict <= {r.p1, r.p0};
  endtask

  task automatic apb_write(input logic [`BRU_APB_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    // Access phase ends on this edge
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`BRU_APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    compare_bit("pready", pready, 1'b1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    // Conditional branches, lane 0 only
    add_row("beq_taken_misp", 32'h1000, br(F_BEQ, 16), NOP, 2'b01, 2'b00, 2'b00,
            32'h5, 32'h5, 0, 0, 0, 32'h1010, 4'b1001, 1, 2'b01, 1, 2'b00);
    add_row("beq_not_taken", 32'h1100, br(F_BEQ, 16), NOP, 2'b01, 2'b00, 2'b00,
            32'h5, 32'h6, 0, 0, 0, 32'h1104, 4'b0000, 1, 2'b00, 0, 2'b00);
    add_row("bne_backward", 32'h1200, br(F_BNE, -8), NOP, 2'b01, 2'b10, 2'b00,
            32'h0, 32'h1, 0, 0, 0, 32'h11F8, 4'b0001, 1, 2'b01, 0, 2'b10);
    add_row("blt_negative", 32'h1300, br(F_BLT, 16), NOP, 2'b01, 2'b10, 2'b00,
            32'hFFFF_FFFF, 32'h1, 0, 0, 0, 32'h1310, 4'b0001, 1, 2'b01, 0, 2'b10);
    add_row("blt_max_min", 32'h1400, br(F_BLT, 16), NOP, 2'b01, 2'b11, 2'b00,
            32'h7FFF_FFFF, 32'h8000_0000, 0, 0, 0, 32'h1404, 4'b1000, 1, 2'b00, 1, 2'b11);
    add_row("bge_min_max", 32'h1500, br(F_BGE, 16), NOP, 2'b01, 2'b01, 2'b00,
            32'h8000_0000, 32'h7FFF_FFFF, 0, 0, 0, 32'h1504, 4'b0000, 1, 2'b00, 0, 2'b01);
    add_row("bge_equal", 32'h1600, br(F_BGE, 16), NOP, 2'b01, 2'b00, 2'b00,
            32'h3, 32'h3, 0, 0, 0, 32'h1610, 4'b1001, 1, 2'b01, 1, 2'b00);
    add_row("bltu_taken", 32'h1700, br(F_BLTU, 16), NOP, 2'b01, 2'b10, 2'b00,
            32'h1, 32'hFFFF_FFFF, 0, 0, 0, 32'h1710, 4'b0001, 1, 2'b01, 0, 2'b10);
    add_row("bltu_not_taken", 32'h1800, br(F_BLTU, 16), NOP, 2'b01, 2'b10, 2'b00,
            32'hFFFF_FFFF, 32'h1, 0, 0, 0, 32'h1804, 4'b1000, 1, 2'b00, 1, 2'b10);
    add_row("bgeu_unsigned", 32'h1900, br(F_BGEU, -8), NOP, 2'b01, 2'b01, 2'b00,
            32'h8000_0000, 32'h7FFF_FFFF, 0, 0, 0, 32'h18F8, 4'b1001, 1, 2'b01, 1, 2'b01);
    add_row("bgeu_not_taken", 32'h1A00, br(F_BGEU, 16), NOP, 2'b01, 2'b00, 2'b00,
            32'h0, 32'h1, 0, 0, 0, 32'h1A04, 4'b0000, 1, 2'b00, 0, 2'b00);
    // Two lanes, oldest redirect wins
    add_row("lane0_misp_wins", 32'h2000, br(F_BNE, 16), JALR, 2'b11, 2'b00, 2'b11,
            32'h1, 32'h2, 0, 0, 1, 32'h2010, 4'b1001, 1, 2'b01, 1, 2'b00);
    add_row("lane1_after_nop", 32'h2100, NOP, br(F_BEQ, 16), 2'b11, 2'b10, 2'b00,
            32'h0, 32'h0, 32'h7, 32'h7, 0, 32'h2114, 4'b1001, 1, 2'b01, 1, 2'b00);
    add_row("two_branches", 32'h2200, br(F_BEQ, 16), br(F_BNE, -8), 2'b11, 2'b00, 2'b10,
            32'h1, 32'h2, 32'h1, 32'h2, 0, 32'h21FC, 4'b0001, 2, 2'b10, 0, 2'b10);
    add_row("jal_then_nop", 32'h2300, jal(256), NOP, 2'b11, 2'b11, 2'b00,
            32'h0, 32'h0, 0, 0, 1, 32'h2308, 4'b0000, 0, 2'b00, 0, 2'b00);
    // Jumps and FENCE.I
    add_row("jal_forward", 32'h3000, jal(2048), NOP, 2'b01, 2'b00, 2'b00,
            32'h0, 32'h0, 0, 0, 0, 32'h3800, 4'b0001, 0, 2'b00, 0, 2'b00);
    add_row("jal_backward", 32'h3100, jal(-32), NOP, 2'b01, 2'b00, 2'b00,
            32'h0, 32'h0, 0, 0, 0, 32'h30E0, 4'b0001, 0, 2'b00, 0, 2'b00);
    add_row("jalr_bit0", 32'h3200, JALR, NOP, 2'b01, 2'b00, 2'b00,
            32'h4001, 32'h10, 0, 0, 0, 32'h4010, 4'b1001, 0, 2'b00, 0, 2'b00);
    add_row("jalr_misaligned", 32'h3300, JALR, NOP, 2'b01, 2'b00, 2'b00,
            32'h4002, 32'h1, 0, 0, 0, 32'h4002, 4'b1011, 0, 2'b00, 0, 2'b00);
    add_row("fence_i", 32'h3400, FENCEI, NOP, 2'b01, 2'b00, 2'b00,
            32'h0, 32'h0, 0, 0, 0, 32'h3404, 4'b1100, 0, 2'b00, 0, 2'b00);
    add_row("branch_misaligned", 32'h3500, br(F_BEQ, 6), NOP, 2'b01, 2'b10, 2'b00,
            32'h0, 32'h0, 0, 0, 0, 32'h3506, 4'b0011, 1, 2'b01, 0, 2'b10);
    // Empty bundle keeps the last nxt_pc
    add_row("empty_bundle", 32'h3600, NOP, NOP, 2'b00, 2'b00, 2'b00,
            32'h0, 32'h0, 0, 0, 0, 32'h3506, 4'b0000, 0, 2'b00, 0, 2'b00);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0]            rd;
    logic                   err;
    logic [`GHIST_BITS-1:0] hist;
    logic [`GHIST_BITS-1:0] exp_bph;
    int                     br_total;
    int                     misp_total;
    row_t                   r;

    clk           = 1'b0;
    rstn          = 1'b0;
    issue_valid   = '0;
    issue_pc      = '0;
    issue_instr   = '0;
    issue_opa     = '0;
    issue_opb     = '0;
    issue_predict = '0;
    stall         = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    errors        = 0;
    tests         = 0;
    failed        = 0;
    cycles        = 0;
    hist          = '0;
    br_total      = 0;
    misp_total    = 0;
    void'($urandom(SEED));
    build_table();
    limit = rows.size() * 6 + APB_CYCLES + 100;

    // Reset pulse then one cycle of restart at PC_INIT
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    start_test("reset_values");
    @(negedge clk);
    compare_bit("flush", flush, 1'b1);
    compare_bit("cacheflush", cacheflush, 1'b1);
    compare_word("nxt_pc", nxt_pc, `PC_INIT);
    @(negedge clk);
    compare_bit("flush", flush, 1'b0);
    compare_bit("cacheflush", cacheflush, 1'b0);
    finish_test();

    // One bundle per row with the result 3 edges later
    foreach (rows[k]) begin
      r = rows[k];
      start_test(r.name);
      exp_bph = hist;
      for (int j = 0; j < r.nbr; j++) begin
        hist = {hist[`GHIST_BITS-2:0], r.tkb[j]};
      end
      br_total   += r.nbr;
      misp_total += int'(r.misp);
      @(posedge clk);
      apply_row(r);
      @(posedge clk);
      issue_valid <= '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      compare_word("nxt_pc", nxt_pc, r.exp_pc);
      compare_bit("flush", flush, r.flags[3]);
      compare_bit("cacheflush", cacheflush, r.flags[2]);
      compare_bit("exception_misaligned", exception_misaligned, r.flags[1]);
      compare_bit("bp_btaken", bp_btaken, r.flags[0]);
      compare_bit("bp_update", bp_update, r.nbr != 0);
      compare_word("bp_history", 32'(bp_history), 32'(exp_bph));
      if (r.v != '0) begin
        compare_word("bp_predict", 32'(bp_predict), 32'(r.bpp));
      end
      finish_test();
    end

    // Statistics from the table
    start_test("apb_counters");
    apb_read(`BRU_BR_CNT, rd, err);
    compare_word("br_cnt", rd, br_total);
    compare_bit("pslverr", err, 1'b0);
    apb_read(`BRU_MISP_CNT, rd, err);
    compare_word("misp_cnt", rd, misp_total);
    compare_bit("pslverr", err, 1'b0);
    finish_test();

    start_test("apb_history");
    apb_read(`BRU_HIST, rd, err);
    compare_word("history", rd, 32'(hist));
    finish_test();

    // Stall over a mispredicting bundle
    start_test("stall_delay");
    r = rows[0];
    r.pc = 32'h5000;
    @(posedge clk);
    apply_row(r);
    @(posedge clk);
    issue_valid <= '0;
    stall       <= 1'b1;
    repeat (STALL_LEN) @(posedge clk);
    stall <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    compare_bit("flush", flush, 1'b0);
    @(posedge clk);
    @(negedge clk);
    compare_bit("flush", flush, 1'b1);
    compare_word("nxt_pc", nxt_pc, 32'h5010);
    finish_test();

    // Younger bundle right behind a redirect
    start_test("kill_after_flush");
    r = rows[0];
    r.pc = 32'h6000;
    @(posedge clk);
    apply_row(r);
    r.pc = 32'h6100;
    @(posedge clk);
    apply_row(r);
    @(posedge clk);
    issue_valid <= '0;
    @(posedge clk);
    @(negedge clk);
    compare_bit("flush", flush, 1'b1);
    compare_word("nxt_pc", nxt_pc, 32'h6010);
    repeat (2) begin
      @(negedge clk);
      compare_bit("flush", flush, 1'b0);
      compare_word("nxt_pc", nxt_pc, 32'h6010);
    end
    finish_test();

    // Debugger PC write redirects fetch
    start_test("debug_pc_write");
    // Taken branch reaches the redirect stage on the access edge
    r = rows[2];
    r.pc = 32'h7000;
    @(posedge clk);
    apply_row(r);
    fork
      apb_write(`BRU_DBG_PC, 32'h0000_8000);
      begin
        @(posedge clk);
        issue_valid <= '0;
      end
    join
    @(negedge clk);
    compare_bit("flush", flush, 1'b1);
    compare_word("nxt_pc", nxt_pc, 32'h0000_8000);
    compare_bit("bp_update", bp_update, 1'b0);
    @(negedge clk);
    compare_bit("flush", flush, 1'b0);
    finish_test();

    start_test("ctrl_clear");
    apb_write(`BRU_CTRL, 32'h1);
    apb_read(`BRU_BR_CNT, rd, err);
    compare_word("br_cnt", rd, 32'h0);
    apb_read(`BRU_MISP_CNT, rd, err);
    compare_word("misp_cnt", rd, 32'h0);
    finish_test();

    // Hole in the register map
    start_test("unmapped_addr");
    apb_read(8'h20, rd, err);
    compare_bit("pslverr", err, 1'b1);
    finish_test();

    $display("Summary: %0d tests, %0d failed, %0d check errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src/bru_top.sv
`include "bru_defs.svh"

module bru_top (
  input  logic                          clk,
  input  logic                          rstn,

  // Issue bundle, lane 0 oldest
  input  logic [`LANES-1:0]             issue_valid,
  input  logic [`LANES-1:0][`XLEN-1:0]  issue_pc,
  input  logic [`LANES-1:0][31:0]       issue_instr,
  input  logic [`LANES-1:0][`XLEN-1:0]  issue_opa,
  input  logic [`LANES-1:0][`XLEN-1:0]  issue_opb,
  input  logic [`LANES-1:0][1:0]        issue_predict,
  input  logic                          stall,

  // Redirect to fetch and predictor
  output logic [`XLEN-1:0]              nxt_pc,
  output logic                          flush,
  output logic                          cacheflush,
  output logic                          exception_misaligned,
  output logic                          bp_update,
  output logic                          bp_btaken,
  output logic [1:0]                    bp_predict,
  output logic [`GHIST_BITS-1:0]        bp_history,

  // APB slave
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`BRU_APB_AW-1:0]        paddr,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr
);

  logic                          dbg_we;
  logic [`XLEN-1:0]              dbg_pc;
  logic [$clog2(`LANES+1)-1:0]   ev_branches;
  logic                          ev_mispredict;
  logic [`GHIST_BITS-1:0]        history;

  bru_lane_if lane_if [`LANES] ();

  ////////////////////////////////////////
  // Issue, lanes, redirect
  ////////////////////////////////////////

  bru_issue u_issue (
    .clk           (clk),
    .rstn          (rstn),
    .stall         (stall),
    .redirect      (flush),
    .issue_valid   (issue_valid),
    .issue_pc      (issue_pc),
    .issue_instr   (issue_instr),
    .issue_opa     (issue_opa),
    .issue_opb     (issue_opb),
    .issue_predict (issue_predict),
    .lanes         (lane_if)
  );

  for (genvar g = 0; g < `LANES; g++) begin : g_lane
    bru_lane u_lane (
      .clk      (clk),
      .rstn     (rstn),
      .stall    (stall),
      .redirect (flush),
      .port     (lane_if[g])
    );
  end

  bru_redirect u_redirect (
    .clk                  (clk),
    .rstn                 (rstn),
    .stall                (stall),
    .dbg_we               (dbg_we),
    .dbg_pc               (dbg_pc),
    .lanes                (lane_if),
    .nxt_pc               (nxt_pc),
    .flush                (flush),
    .cacheflush           (cacheflush),
    .exception_misaligned (exception_misaligned),
    .bp_update            (bp_update),
    .bp_btaken            (bp_btaken),
    .bp_predict           (bp_predict),
    .bp_history           (bp_history),
    .ev_branches          (ev_branches),
    .ev_mispredict        (ev_mispredict),
    .history              (history)
  );

  // Statistics and debugger access
  bru_apb_regs u_apb_regs (
    .clk           (clk),
    .rstn          (rstn),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .ev_branches   (ev_branches),
    .ev_mispredict (ev_mispredict),
    .history       (history),
    .dbg_we        (dbg_we),
    .dbg_pc        (dbg_pc)
  );

endmodule

//--- src/bru_apb_regs.sv
`include "bru_defs.svh"

module bru_apb_regs (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [`BRU_APB_AW-1:0]       paddr,
  input  logic [31:0]                  pwdata,
  output logic [31:0]                  prdata,
  output logic                         pready,
  output logic                         pslverr,
  input  logic [$clog2(`LANES+1)-1:0]  ev_branches,
  input  logic                         ev_mispredict,
  input  logic [`GHIST_BITS-1:0]       history,
  output logic                         dbg_we,
  output logic [`XLEN-1:0]             dbg_pc
);

  logic              access;
  logic              mapped;
  logic              wr;
  logic              clr;
  logic [`XLEN-1:0]  dbg_pc_q;
  logic [31:0]       br_cnt;
  logic [31:0]       misp_cnt;
  logic [32:0]       br_sum;
  logic [32:0]       misp_sum;

  // Zero wait states
  assign pready = 1'b1;
  assign access = psel & penable;

  assign mapped = (paddr == `BRU_CTRL) || (paddr == `BRU_DBG_PC) ||
                  (paddr == `BRU_BR_CNT) || (paddr == `BRU_MISP_CNT) ||
                  (paddr == `BRU_HIST);
  assign pslverr = access & ~mapped;
  assign wr      = access & pwrite & mapped;

  // CTRL bit 0 is a self-clearing counter reset
  assign clr = wr & (paddr == `BRU_CTRL) & pwdata[0];

  // PC write goes straight to the redirect stage
  assign dbg_we = wr & (paddr == `BRU_DBG_PC);
  assign dbg_pc = pwdata[`XLEN-1:0];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_pc_q <= '0;
    end else if (dbg_we) begin
      dbg_pc_q <= dbg_pc;
    end
  end

  ////////////////////////////////////////
  // Saturating statistics
  ////////////////////////////////////////

  assign br_sum   = {1'b0, br_cnt} + 33'(ev_branches);
  assign misp_sum = {1'b0, misp_cnt} + 33'(ev_mispredict);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      br_cnt   <= '0;
      misp_cnt <= '0;
    end else if (clr) begin
      br_cnt   <= '0;
      misp_cnt <= '0;
    end else begin
      br_cnt   <= br_sum[32] ? '1 : br_sum[31:0];
      misp_cnt <= misp_sum[32] ? '1 : misp_sum[31:0];
    end
  end

  // Read mux
  always_comb begin
    case (paddr)
      `BRU_DBG_PC:   prdata = 32'(dbg_pc_q);
      `BRU_BR_CNT:   prdata = br_cnt;
      `BRU_MISP_CNT: prdata = misp_cnt;
      `BRU_HIST:     prdata = 32'(history);
      default:       prdata = '0;
    endcase
  end

endmodule

//--- src/bru_redirect.sv
`include "bru_defs.svh"

module bru_redirect (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           stall,
  input  logic                           dbg_we,
  input  logic [`XLEN-1:0]               dbg_pc,
  bru_lane_if.drain                      lanes [`LANES],
  output logic [`XLEN-1:0]               nxt_pc,
  output logic                           flush,
  output logic                           cacheflush,
  output logic                           exception_misaligned,
  output logic                           bp_update,
  output logic                           bp_btaken,
  output logic [1:0]                     bp_predict,
  output logic [`GHIST_BITS-1:0]         bp_history,
  output logic [$clog2(`LANES+1)-1:0]    ev_branches,
  output logic                           ev_mispredict,
  output logic [`GHIST_BITS-1:0]         history
);

  bru_pkg::bru_res_t                  res_a [`LANES];
  bru_pkg::bru_res_t                  sel;
  logic                               any_valid;
  logic                               any_br;
  logic                               done;
  logic                               live;
  logic [$clog2(`LANES+1)-1:0]        n_br;
  logic                               misp;
  logic [`GHIST_BITS-1:0]             hist_n;
  logic [`GHIST_BITS-1:0]             hist_q;

  for (genvar g = 0; g < `LANES; g++) begin : g_res
    assign res_a[g] = lanes[g].res;
  end

  // Results behind a flush that is already out are stale
  assign live = ~flush;

  ////////////////////////////////////////
  // Oldest redirecting lane
  ////////////////////////////////////////

  always_comb begin
    sel       = '0;
    any_valid = 1'b0;
    any_br    = 1'b0;
    done      = 1'b0;
    n_br      = '0;
    misp      = 1'b0;
    hist_n    = hist_q;
    for (int i = 0; i < `LANES; i++) begin
      if (live && !done && res_a[i].valid) begin
        any_valid = 1'b1;
        sel       = res_a[i];
        if (res_a[i].is_branch) begin
          // Oldest branch shifted in first
          any_br = 1'b1;
          n_br   = n_br + 1'b1;
          misp   = misp | res_a[i].mispredict;
          hist_n = (hist_n << 1) | `GHIST_BITS'(res_a[i].taken);
        end
        // Everything younger is on the wrong path
        if (res_a[i].flush) begin
          done = 1'b1;
        end
      end
    end
  end

  // Events only when the bundle is really taken
  assign ev_branches   = (stall || dbg_we) ? '0 : n_br;
  assign ev_mispredict = ~stall & ~dbg_we & misp;

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush                <= 1'b1;
      cacheflush           <= 1'b1;
      nxt_pc               <= `XLEN'(`PC_INIT);
      exception_misaligned <= 1'b0;
      bp_update            <= 1'b0;
      bp_btaken            <= 1'b0;
      bp_predict           <= 2'b00;
      bp_history           <= '0;
      hist_q               <= '0;
    end else if (dbg_we) begin
      // Debugger PC write wins, history untouched
      flush                <= 1'b1;
      cacheflush           <= 1'b0;
      nxt_pc               <= dbg_pc;
      exception_misaligned <= 1'b0;
      bp_update            <= 1'b0;
      bp_btaken            <= 1'b0;
      bp_predict           <= 2'b00;
    end else if (!stall) begin
      flush                <= any_valid & sel.flush;
      cacheflush           <= any_valid & sel.cacheflush;
      exception_misaligned <= any_valid & sel.misaligned;
      bp_update            <= any_br;
      bp_btaken            <= sel.taken;
      bp_predict           <= sel.predict;
      // History as seen before this bundle
      bp_history           <= hist_q;
      hist_q               <= hist_n;
      if (any_valid) begin
        nxt_pc <= sel.nxt_pc;
      end
    end
  end

  assign history = hist_q;

endmodule

//--- src/bru_lane.sv
`include "bru_defs.svh"

module bru_lane (
  input  logic     clk,
  input  logic     rstn,
  input  logic     stall,
  input  logic     redirect,
  bru_lane_if.lane port
);

  bru_pkg::opcode_e  opcode;
  bru_pkg::brfunc_e  funct3;
  logic [`XLEN-1:0]  imm_j;
  logic [`XLEN-1:0]  imm_b;
  logic [`XLEN-1:0]  pc_plus4;
  logic              cond;
  logic              cond_ok;
  logic              is_br;
  logic              taken;
  logic              do_flush;
  logic              cflush;
  logic [`XLEN-1:0]  nxt;
  bru_pkg::bru_res_t res_n;
  bru_pkg::bru_res_t res_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign opcode = bru_pkg::opcode_e'(port.instr[6:2]);
  assign funct3 = bru_pkg::brfunc_e'(port.instr[14:12]);

  // J and B immediates, bit 0 always zero
  assign imm_j = {{(`XLEN-20){port.instr[31]}}, port.instr[19:12], port.instr[20],
                  port.instr[30:25], port.instr[24:21], 1'b0};
  assign imm_b = {{(`XLEN-12){port.instr[31]}}, port.instr[7],
                  port.instr[30:25], port.instr[11:8], 1'b0};

  assign pc_plus4 = port.pc + `XLEN'(4);

  // Branch condition
  always_comb begin
    cond_ok = 1'b1;
    case (funct3)
      bru_pkg::BEQ:  cond = (port.opa == port.opb);
      bru_pkg::BNE:  cond = (port.opa != port.opb);
      bru_pkg::BLT:  cond = ($signed(port.opa) <  $signed(port.opb));
      bru_pkg::BGE:  cond = ($signed(port.opa) >= $signed(port.opb));
      bru_pkg::BLTU: cond = (port.opa <  port.opb);
      bru_pkg::BGEU: cond = (port.opa >= port.opb);
      default: begin
        // Reserved funct3, handled as a plain instruction
        cond    = 1'b0;
        cond_ok = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Next PC and control
  ////////////////////////////////////////

  always_comb begin
    is_br    = 1'b0;
    taken    = 1'b0;
    do_flush = 1'b0;
    cflush   = 1'b0;
    nxt      = pc_plus4;
    case (opcode)
      bru_pkg::OPC_JAL: begin
        // Fetch already followed it
        taken = 1'b1;
        nxt   = port.pc + imm_j;
      end
      bru_pkg::OPC_JALR: begin
        taken    = 1'b1;
        do_flush = 1'b1;
        nxt      = (port.opa + port.opb) & ~`XLEN'(1);
      end
      bru_pkg::OPC_BRANCH: begin
        is_br    = cond_ok;
        taken    = cond_ok & cond;
        do_flush = cond_ok & (taken ^ port.predict[1]);
        if (taken) begin
          nxt = port.pc + imm_b;
        end
      end
      bru_pkg::OPC_MISCMEM: begin
        // Other FENCE forms fall through as pc+4
        if (port.instr == bru_pkg::FENCE_I) begin
          do_flush = 1'b1;
          cflush   = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    res_n.valid      = port.req_valid;
    res_n.is_branch  = is_br;
    res_n.taken      = taken;
    res_n.mispredict = is_br & do_flush;
    res_n.flush      = do_flush;
    res_n.cacheflush = cflush;
    res_n.misaligned = (|nxt[1:0]) & ((opcode == bru_pkg::OPC_JALR) | (is_br & taken));
    res_n.nxt_pc     = nxt;
    res_n.predict    = port.predict;
  end

  // Result register, redirect drops it
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      res_q <= '0;
    end else if (redirect) begin
      res_q.valid <= 1'b0;
    end else if (!stall) begin
      res_q <= res_n;
    end
  end

  assign port.res = res_q;

endmodule

//--- src/bru_issue.sv
`include "bru_defs.svh"

module bru_issue (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          stall,
  input  logic                          redirect,
  input  logic [`LANES-1:0]             issue_valid,
  input  logic [`LANES-1:0][`XLEN-1:0]  issue_pc,
  input  logic [`LANES-1:0][31:0]       issue_instr,
  input  logic [`LANES-1:0][`XLEN-1:0]  issue_opa,
  input  logic [`LANES-1:0][`XLEN-1:0]  issue_opb,
  input  logic [`LANES-1:0][1:0]        issue_predict,
  bru_lane_if.feeder                    lanes [`LANES]
);

  logic [`LANES-1:0]             valid_q;
  logic [`LANES-1:0][`XLEN-1:0]  pc_q;
  logic [`LANES-1:0][31:0]       instr_q;
  logic [`LANES-1:0][`XLEN-1:0]  opa_q;
  logic [`LANES-1:0][`XLEN-1:0]  opb_q;
  logic [`LANES-1:0][1:0]        predict_q;

  // Valid bits, kill beats stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid_q <= '0;
    end else if (redirect) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q <= issue_valid;
    end
  end

  // Bundle payload, frozen under stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q      <= issue_pc;
      instr_q   <= issue_instr;
      opa_q     <= issue_opa;
      opb_q     <= issue_opb;
      predict_q <= issue_predict;
    end
  end

  // Fan out, lane 0 is the oldest
  for (genvar g = 0; g < `LANES; g++) begin : g_fan
    assign lanes[g].req_valid = valid_q[g];
    assign lanes[g].pc        = pc_q[g];
    assign lanes[g].instr     = instr_q[g];
    assign lanes[g].opa       = opa_q[g];
    assign lanes[g].opb       = opb_q[g];
    assign lanes[g].predict   = predict_q[g];
  end

endmodule

//--- src/bru_lane_if.sv
`include "bru_defs.svh"

interface bru_lane_if;

  // Request from the issue register
  logic              req_valid;
  logic [`XLEN-1:0]  pc;
  logic [31:0]       instr;
  logic [`XLEN-1:0]  opa;
  logic [`XLEN-1:0]  opb;
  logic [1:0]        predict;

  // Registered lane result
  bru_pkg::bru_res_t res;

  // Issue side
  modport feeder (output req_valid, pc, instr, opa, opb, predict);

  // Resolution lane
  modport lane (input req_valid, pc, instr, opa, opb, predict, output res);

  // Redirect side only looks at results
  modport drain (input res);

endinterface

//--- src/bru_pkg.sv
`include "bru_defs.svh"

package bru_pkg;

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OPC_MISCMEM = 5'b00011,
    OPC_BRANCH  = 5'b11000,
    OPC_JALR    = 5'b11001,
    OPC_JAL     = 5'b11011
  } opcode_e;

  // Branch condition, funct3
  // 3'b010 and 3'b011 are reserved
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } brfunc_e;

  // FENCE.I with all other fields zero
  localparam logic [31:0] FENCE_I = 32'h0000_100F;

  ////////////////////////////////////////
  // Lane result
  ////////////////////////////////////////

  typedef struct packed {
    // Lane holds a live instruction
    logic              valid;
    // Conditional branch, feeds history and counters
    logic              is_branch;
    logic              taken;
    // Predictor got the direction wrong
    logic              mispredict;
    // Pipeline must restart at nxt_pc
    logic              flush;
    // Instruction cache must be invalidated too
    logic              cacheflush;
    // Target not on a 4-byte boundary
    logic              misaligned;
    logic [`XLEN-1:0]  nxt_pc;
    // Prediction as it came in
    logic [1:0]        predict;
  } bru_res_t;

endpackage

//--- include/bru_defs.svh
`ifndef BRU_DEFS_SVH
`define BRU_DEFS_SVH

// Datapath and PC width
`define XLEN        32
// Parallel resolution lanes, 1, 2 or 4
`define LANES       2
// Global branch history length
`define GHIST_BITS  4
// Fetch restarts here after reset
`define PC_INIT     'h200

// APB address width, byte addressed
`define BRU_APB_AW  8

// APB register map
`define BRU_CTRL     8'h00
`define BRU_DBG_PC   8'h04
`define BRU_BR_CNT   8'h08
`define BRU_MISP_CNT 8'h0C
`define BRU_HIST     8'h10

`endif
